// File: Makefile
# Verilator build and run of the SMU SPI testbench.

VERILATOR ?= verilator
TOP       ?= smu_spi_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= SIMULATION PASSED

.PHONY: sim clean

# output goes to the terminal, the status comes from grep
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)

// File: files.f
hdl/smu_regs_pkg.sv
hdl/spi_frame_pkg.sv
hdl/spi_frame_shifter.sv
hdl/reg_bank_ctrl.sv
hdl/spi_route.sv
hdl/smu_spi_top.sv
test/smu_spi_assertions.sv
test/smu_spi_checker.sv
test/smu_spi_tb.sv

// File: hdl/reg_bank_ctrl.sv
// Control register bank behind the special SPI select.
// Decodes each valid frame, applies the set/clear/toggle rule, loads
// the mux register directly, handles soft reset, and returns the
// addressed register for readback.
`timescale 1ns/1ps

module reg_bank_ctrl
  import smu_regs_pkg::*;
  import spi_frame_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 frame_valid,
  input  frame_word_u          frame_word,
  input  logic                 addr_valid,
  input  logic [ADDR_BITS-1:0] rx_addr,
  output logic [REG_W-1:0]     rd_data,
  output logic [REG_W-1:0]     reg_led,
  output logic [REG_W-1:0]     reg_mux,
  output logic [REG_W-1:0]     reg_dac,
  output logic [REG_W-1:0]     reg_rails,
  output logic [REG_W-1:0]     reg_adc,
  output logic [REG_W-1:0]     reg_clamp1,
  output logic [REG_W-1:0]     reg_relay,
  output logic [REG_W-1:0]     reg_rails_oe
);

  //////////////////////////////////////////////////////////////////////
  // update rule
  //////////////////////////////////////////////////////////////////////

  // set and clear on the same bit means toggle
  // any toggle bit turns the whole write into a toggle
  function automatic logic [REG_W-1:0] apply_update(
    input logic [REG_W-1:0] cur,
    input logic [REG_W-1:0] clr,
    input logic [REG_W-1:0] set
  );
    logic [REG_W-1:0] tgl;
    tgl = set & clr;
    if (tgl != '0)
      apply_update = cur ^ tgl;
    else
      // set first, then clear
      apply_update = (cur | set) & ~clr;
  endfunction

  logic [REG_W-1:0] wr_clr;
  logic [REG_W-1:0] wr_set;

  assign wr_clr = frame_word.wr.clr;
  assign wr_set = frame_word.wr.set;

  //////////////////////////////////////////////////////////////////////
  // register writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      reg_led      <= RST_DEFAULT;
      reg_mux      <= RST_DEFAULT;
      reg_dac      <= RST_DEFAULT;
      reg_rails    <= RST_DEFAULT;
      reg_adc      <= RST_DEFAULT;
      reg_clamp1   <= RST_CLAMP1;
      reg_relay    <= RST_DEFAULT;
      reg_rails_oe <= RST_RAILS_OE;
    end
    else if (frame_valid)
    begin
      case (frame_word.wr.addr)
        ADDR_LED:      reg_led    <= apply_update(reg_led, wr_clr, wr_set);
        // mux takes the data byte as is
        ADDR_MUX:      reg_mux    <= frame_word.raw.data[REG_W-1:0];
        ADDR_DAC:      reg_dac    <= apply_update(reg_dac, wr_clr, wr_set);
        ADDR_RAILS:    reg_rails  <= apply_update(reg_rails, wr_clr, wr_set);
        ADDR_ADC:      reg_adc    <= apply_update(reg_adc, wr_clr, wr_set);
        ADDR_CLAMP1:   reg_clamp1 <= apply_update(reg_clamp1, wr_clr, wr_set);
        ADDR_RELAY:    reg_relay  <= apply_update(reg_relay, wr_clr, wr_set);
        ADDR_RAILS_OE: reg_rails_oe <= apply_update(reg_rails_oe, wr_clr, wr_set);
        // soft reset, same values as arst_n
        ADDR_SOFT_RST:
        begin
          reg_led      <= RST_DEFAULT;
          reg_mux      <= RST_DEFAULT;
          reg_dac      <= RST_DEFAULT;
          reg_rails    <= RST_DEFAULT;
          reg_adc      <= RST_DEFAULT;
          reg_clamp1   <= RST_CLAMP1;
          reg_relay    <= RST_DEFAULT;
          reg_rails_oe <= RST_RAILS_OE;
        end
        // unmapped, drop it
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////////////////////////

  // only meaningful once the address byte is complete
  always_comb
  begin
    rd_data = '0;
    if (addr_valid)
    begin
      case (rx_addr)
        ADDR_LED:      rd_data = reg_led;
        ADDR_MUX:      rd_data = reg_mux;
        ADDR_DAC:      rd_data = reg_dac;
        ADDR_RAILS:    rd_data = reg_rails;
        ADDR_ADC:      rd_data = reg_adc;
        ADDR_CLAMP1:   rd_data = reg_clamp1;
        ADDR_RELAY:    rd_data = reg_relay;
        ADDR_RAILS_OE: rd_data = reg_rails_oe;
        // soft reset and unmapped read as zero
        default:       rd_data = '0;
      endcase
    end
  end

endmodule

// File: hdl/smu_regs_pkg.sv
// Register map of the SMU control bank.
// Addresses, register width and reset values shared by the bank,
// the SPI router and the testbench model.

package smu_regs_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  // every control register is one nibble
  localparam int REG_W = 4;

  // routed peripherals
  // bit 0 adc03, 1 dac, 2 flash, 3 adc02
  localparam int N_PERIPH = 4;

  //////////////////////////////////////////////////////////////////////
  // register addresses, first byte of a frame
  //////////////////////////////////////////////////////////////////////

  localparam logic [7:0] ADDR_LED      = 8'd7;
  // mux is a direct load, not set/clear
  localparam logic [7:0] ADDR_MUX      = 8'd8;
  localparam logic [7:0] ADDR_DAC      = 8'd9;
  localparam logic [7:0] ADDR_RAILS    = 8'd10;
  // write-only strobe, no storage behind it
  localparam logic [7:0] ADDR_SOFT_RST = 8'd11;
  localparam logic [7:0] ADDR_ADC      = 8'd14;
  localparam logic [7:0] ADDR_CLAMP1   = 8'd15;
  localparam logic [7:0] ADDR_RELAY    = 8'd19;
  localparam logic [7:0] ADDR_RAILS_OE = 8'd24;

  //////////////////////////////////////////////////////////////////////
  // reset values
  //////////////////////////////////////////////////////////////////////

  // clamp drives are active low, so all ones keeps them off
  localparam logic [REG_W-1:0] RST_CLAMP1   = 4'b1111;

  // rails output enable is active low
  // hold it off until the mcu turns the rails on
  localparam logic [REG_W-1:0] RST_RAILS_OE = 4'b0001;

  // everything else comes up cleared
  localparam logic [REG_W-1:0] RST_DEFAULT  = '0;

endpackage

// File: hdl/smu_spi_top.sv
// Top level of the SMU SPI control block.
// Connects the frame shifter, the register bank and the peripheral
// router; all external pins of the block are on this module.
`timescale 1ns/1ps

module smu_spi_top
  import smu_regs_pkg::*;
  import spi_frame_pkg::*;
(
  input  logic                clk,
  input  logic                arst_n,
  // spi from the mcu
  input  logic                sclk,
  input  logic                cs_n,
  input  logic                special_n,
  input  logic                mosi,
  output logic                miso,
  // peripheral side, bit 0 adc03, 1 dac, 2 flash, 3 adc02
  output logic [N_PERIPH-1:0] periph_cs_n,
  input  logic [N_PERIPH-1:0] periph_miso,
  // control registers to the board
  output logic [REG_W-1:0]    reg_led,
  output logic [REG_W-1:0]    reg_mux,
  output logic [REG_W-1:0]    reg_dac,
  output logic [REG_W-1:0]    reg_rails,
  output logic [REG_W-1:0]    reg_adc,
  output logic [REG_W-1:0]    reg_clamp1,
  output logic [REG_W-1:0]    reg_relay,
  output logic [REG_W-1:0]    reg_rails_oe
);

  // shifter to bank
  logic                 frame_valid;
  frame_word_u          frame_word;
  logic                 addr_valid;
  logic [ADDR_BITS-1:0] rx_addr;
  logic [REG_W-1:0]     rd_data;
  // bank readback to router
  logic                 bank_miso;

  spi_frame_shifter i_spi_frame_shifter (
    .clk         (clk),
    .arst_n      (arst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .special_n   (special_n),
    .mosi        (mosi),
    .rd_data     (rd_data),
    .bank_miso   (bank_miso),
    .frame_valid (frame_valid),
    .frame_word  (frame_word),
    .addr_valid  (addr_valid),
    .rx_addr     (rx_addr)
  );

  reg_bank_ctrl i_reg_bank_ctrl (
    .clk          (clk),
    .arst_n       (arst_n),
    .frame_valid  (frame_valid),
    .frame_word   (frame_word),
    .addr_valid   (addr_valid),
    .rx_addr      (rx_addr),
    .rd_data      (rd_data),
    .reg_led      (reg_led),
    .reg_mux      (reg_mux),
    .reg_dac      (reg_dac),
    .reg_rails    (reg_rails),
    .reg_adc      (reg_adc),
    .reg_clamp1   (reg_clamp1),
    .reg_relay    (reg_relay),
    .reg_rails_oe (reg_rails_oe)
  );

  // raw pins here, routing must not wait on the synchronizers
  spi_route i_spi_route (
    .reg_mux     (reg_mux),
    .cs_n        (cs_n),
    .special_n   (special_n),
    .bank_miso   (bank_miso),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

endmodule

// File: hdl/spi_frame_pkg.sv
// Layout of the 16-bit SPI control frame.
// Frame length, field widths and the union used to decode one frame
// word either as a set/clear write or as an address plus data byte.

package spi_frame_pkg;

  // bits per frame and per field
  localparam int FRAME_BITS  = 16;
  localparam int ADDR_BITS   = 8;
  localparam int DATA_BITS   = FRAME_BITS - ADDR_BITS;
  localparam int NIBBLE_BITS = 4;

  // bit counter must hold one past a full frame
  // so that a seventeenth bit can be seen
  localparam int CNT_BITS = $clog2(FRAME_BITS + 2);

  // counter values the shifter compares against
  localparam logic [CNT_BITS-1:0] CNT_ADDR = CNT_BITS'(ADDR_BITS);
  localparam logic [CNT_BITS-1:0] CNT_FULL = CNT_BITS'(FRAME_BITS);

  // one frame, msb first on the wire
  // wr for set/clear/toggle registers, raw for the mux load
  typedef union packed {
    struct packed {
      logic [ADDR_BITS-1:0]   addr;
      // high nibble clears, low nibble sets
      logic [NIBBLE_BITS-1:0] clr;
      logic [NIBBLE_BITS-1:0] set;
    } wr;
    struct packed {
      logic [ADDR_BITS-1:0] addr;
      logic [DATA_BITS-1:0] data;
    } raw;
  } frame_word_u;

endpackage

// File: hdl/spi_frame_shifter.sv
// SPI slave front end for the control bank.
// Samples the SPI pins into the clk domain, shifts frames in on rising
// sclk, shifts the readback byte out on falling sclk and flags each
// complete 16-bit frame with a one-cycle strobe.
`timescale 1ns/1ps

module spi_frame_shifter
  import spi_frame_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   sclk,
  input  logic                   cs_n,
  input  logic                   special_n,
  input  logic                   mosi,
  input  logic [NIBBLE_BITS-1:0] rd_data,
  output logic                   bank_miso,
  output logic                   frame_valid,
  output frame_word_u            frame_word,
  output logic                   addr_valid,
  output logic [ADDR_BITS-1:0]   rx_addr
);

  //////////////////////////////////////////////////////////////////////
  // pin synchronizers and edge detect
  //////////////////////////////////////////////////////////////////////

  // two flops per pin, [1] is the synchronized level
  logic [1:0] sclk_sync;
  logic [1:0] cs_n_sync;
  logic [1:0] special_n_sync;
  logic [1:0] mosi_sync;
  // previous synchronized levels
  logic       sclk_prev;
  logic       cs_n_prev;

  logic       sclk_rise;
  logic       sclk_fall;
  logic       cs_rise;
  logic       in_frame;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // idle bus levels
      sclk_sync      <= 2'b00;
      cs_n_sync      <= 2'b11;
      special_n_sync <= 2'b11;
      mosi_sync      <= 2'b00;
      sclk_prev      <= 1'b0;
      cs_n_prev      <= 1'b1;
    end
    else
    begin
      sclk_sync      <= {sclk_sync[0], sclk};
      cs_n_sync      <= {cs_n_sync[0], cs_n};
      special_n_sync <= {special_n_sync[0], special_n};
      mosi_sync      <= {mosi_sync[0], mosi};
      sclk_prev      <= sclk_sync[1];
      cs_n_prev      <= cs_n_sync[1];
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_prev;
  assign sclk_fall = ~sclk_sync[1] & sclk_prev;
  // end of transfer, one cycle
  assign cs_rise   = cs_n_sync[1] & ~cs_n_prev;
  // both selects asserted, the bank owns the bus
  assign in_frame  = ~cs_n_sync[1] & ~special_n_sync[1];

  //////////////////////////////////////////////////////////////////////
  // receive side
  //////////////////////////////////////////////////////////////////////

  logic [FRAME_BITS-1:0] shift_q;
  logic [CNT_BITS-1:0]   bit_cnt;
  // special_n went high at some point during cs_n low
  logic                  special_lost;

  // frame shift register and latched address, payload only
  always_ff @(posedge clk)
  begin
    if (in_frame && sclk_rise)
    begin
      // msb first, shift toward the top
      shift_q <= {shift_q[FRAME_BITS-2:0], mosi_sync[1]};
      // eighth bit completes the address byte
      if (bit_cnt == CNT_ADDR - 1'b1)
        rx_addr <= {shift_q[ADDR_BITS-2:0], mosi_sync[1]};
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt      <= '0;
      special_lost <= 1'b0;
      frame_valid  <= 1'b0;
    end
    else
    begin
      // count and flag from before the clear below
      frame_valid <= cs_rise && (bit_cnt == CNT_FULL) && !special_lost;
      if (cs_n_sync[1])
      begin
        bit_cnt      <= '0;
        special_lost <= 1'b0;
      end
      else
      begin
        if (special_n_sync[1])
          special_lost <= 1'b1;
        // saturate one past a full frame, long frames stay invalid
        if (in_frame && sclk_rise && bit_cnt <= CNT_FULL)
          bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  assign addr_valid = (bit_cnt >= CNT_ADDR);
  assign frame_word = shift_q;

  //////////////////////////////////////////////////////////////////////
  // readback, second byte of the frame
  //////////////////////////////////////////////////////////////////////

  logic [DATA_BITS-1:0] tx_byte;
  logic [DATA_BITS-1:0] tx_shift;

  // register value zero-extended to a byte
  assign tx_byte = {{(DATA_BITS - NIBBLE_BITS){1'b0}}, rd_data};

  always_ff @(posedge clk)
  begin
    if (in_frame && sclk_fall)
    begin
      if (bit_cnt == CNT_ADDR)
        tx_shift <= {tx_byte[DATA_BITS-2:0], 1'b0};
      else
        tx_shift <= {tx_shift[DATA_BITS-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      bank_miso <= 1'b0;
    else if (cs_n_sync[1])
      bank_miso <= 1'b0;
    else if (in_frame && sclk_fall)
    begin
      // first falling edge after the address puts out the msb
      if (bit_cnt == CNT_ADDR)
        bank_miso <= tx_byte[DATA_BITS-1];
      else if (bit_cnt > CNT_ADDR && bit_cnt < CNT_FULL)
        bank_miso <= tx_shift[DATA_BITS-1];
      else
        bank_miso <= 1'b0;
    end
  end

endmodule

// File: hdl/spi_route.sv
// Peripheral routing of the shared SPI port.
// Fans the chip select out to the peripheral picked by the mux
// register and selects MISO from the bank or the peripherals.
`timescale 1ns/1ps

module spi_route
  import smu_regs_pkg::*;
(
  input  logic [REG_W-1:0]    reg_mux,
  input  logic                cs_n,
  input  logic                special_n,
  input  logic                bank_miso,
  input  logic [N_PERIPH-1:0] periph_miso,
  output logic [N_PERIPH-1:0] periph_cs_n,
  output logic                miso
);

  // pure gates, no clk
  // pins come straight in so peripherals see no added latency

  //////////////////////////////////////////////////////////////////////
  // chip select fan-out
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    // special asserted, the bank owns the frame
    // keep every peripheral deselected so none picks up the write
    if (special_n && !cs_n)
      periph_cs_n = ~reg_mux;
    else
      periph_cs_n = '1;
  end

  //////////////////////////////////////////////////////////////////////
  // miso select
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    if (!special_n)
      miso = bank_miso;
    else
      // any selected peripheral drives the line
      miso = |(reg_mux & periph_miso);
  end

endmodule

// File: test/smu_spi_assertions.sv
// Concurrent checks on the SMU SPI top level.
// Attached to smu_spi_top by the bind at the end of this file.
`timescale 1ns/1ps

module smu_spi_assertions
  import smu_regs_pkg::*;
(
  input logic                clk,
  input logic                arst_n,
  input logic                special_n,
  input logic [N_PERIPH-1:0] periph_cs_n,
  input logic                frame_valid
);

  // number of failed checks so far
  int fail_cnt = 0;

  // bank frames never reach a peripheral
  a_quiet_in_bank: assert property (@(posedge clk) disable iff (!arst_n)
    !special_n |-> periph_cs_n == '1)
  else
  begin
    $error("peripheral selected while special_n is low, periph_cs_n %b", periph_cs_n);
    fail_cnt++;
  end

  // never two peripherals on the bus
  a_one_periph: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(~periph_cs_n))
  else
  begin
    $error("more than one peripheral selected, periph_cs_n %b", periph_cs_n);
    fail_cnt++;
  end

  // strobe is a single cycle
  a_frame_strobe: assert property (@(posedge clk) disable iff (!arst_n)
    frame_valid |=> !frame_valid)
  else
  begin
    $error("frame_valid high on two cycles in a row");
    fail_cnt++;
  end

endmodule

bind smu_spi_top smu_spi_assertions i_smu_spi_assertions (
  .clk         (clk),
  .arst_n      (arst_n),
  .special_n   (special_n),
  .periph_cs_n (periph_cs_n),
  .frame_valid (frame_valid)
);

// File: test/smu_spi_checker.sv
// Scoreboard for the SMU SPI block.
// Decodes the SPI pins, keeps a model of the register bank and the router,
// compares the DUT outputs and prints one line per finished test.
`timescale 1ns/1ps

module smu_spi_checker
  import smu_regs_pkg::*;
  import spi_frame_pkg::*;
(
  input  logic                clk,
  input  logic                arst_n,
  input  logic                sclk,
  input  logic                cs_n,
  input  logic                special_n,
  input  logic                mosi,
  input  logic                miso,
  input  logic [N_PERIPH-1:0] periph_miso,
  input  logic [N_PERIPH-1:0] periph_cs_n,
  input  logic [REG_W-1:0]    reg_led,
  input  logic [REG_W-1:0]    reg_mux,
  input  logic [REG_W-1:0]    reg_dac,
  input  logic [REG_W-1:0]    reg_rails,
  input  logic [REG_W-1:0]    reg_adc,
  input  logic [REG_W-1:0]    reg_clamp1,
  input  logic [REG_W-1:0]    reg_relay,
  input  logic [REG_W-1:0]    reg_rails_oe,
  output int                  test_cnt,
  output int                  err_cnt
);

  // slots: led, mux, dac, rails, adc, clamp1, relay, rails_oe
  logic [REG_W-1:0]      model [0:7];
  logic                  sclk_q;
  logic                  cs_n_q;
  logic [FRAME_BITS-1:0] rx_word;
  logic [7:0]            rb_byte;
  logic [7:0]            exp_rb;
  logic                  spec_high;
  logic                  rb_check;
  logic                  rst_done;
  // router model outputs
  logic [N_PERIPH-1:0]   exp_cs;
  logic                  exp_miso;
  int                    bit_cnt;
  int                    chk_wait;
  int                    test_errs;
  int                    s;
  string                 test_name;
  frame_word_u           fw;

  //////////////////////////////////////////////////////////////////////
  // register map model
  //////////////////////////////////////////////////////////////////////

  function automatic int slot_of(input logic [7:0] addr);
    case (addr)
      ADDR_LED:      slot_of = 0;
      ADDR_MUX:      slot_of = 1;
      ADDR_DAC:      slot_of = 2;
      ADDR_RAILS:    slot_of = 3;
      ADDR_ADC:      slot_of = 4;
      ADDR_CLAMP1:   slot_of = 5;
      ADDR_RELAY:    slot_of = 6;
      ADDR_RAILS_OE: slot_of = 7;
      default:       slot_of = -1;
    endcase
  endfunction

  function automatic string slot_name(input int n);
    case (n)
      0:       slot_name = "led";
      1:       slot_name = "mux";
      2:       slot_name = "dac";
      3:       slot_name = "rails";
      4:       slot_name = "adc";
      5:       slot_name = "clamp1";
      6:       slot_name = "relay";
      default: slot_name = "rails_oe";
    endcase
  endfunction

  function automatic logic [REG_W-1:0] dut_value(input int n);
    case (n)
      0:       dut_value = reg_led;
      1:       dut_value = reg_mux;
      2:       dut_value = reg_dac;
      3:       dut_value = reg_rails;
      4:       dut_value = reg_adc;
      5:       dut_value = reg_clamp1;
      6:       dut_value = reg_relay;
      default: dut_value = reg_rails_oe;
    endcase
  endfunction

  // unmapped and soft reset read back as zero
  function automatic logic [REG_W-1:0] read_model(input logic [7:0] addr);
    read_model = (slot_of(addr) >= 0) ? model[slot_of(addr)] : '0;
  endfunction

  // clamps and rails_oe come up off, the rest cleared
  task automatic reset_model();
    int n;
    for (n = 0; n < 8; n++)
      model[n] = '0;
    model[slot_of(ADDR_CLAMP1)]   = 4'b1111;
    model[slot_of(ADDR_RAILS_OE)] = 4'b0001;
  endtask

  // bit by bit
  // any bit with both set and clear makes the whole write a toggle
  function automatic logic [REG_W-1:0] next_value(input logic [REG_W-1:0] cur,
                                                  input logic [REG_W-1:0] clr,
                                                  input logic [REG_W-1:0] set);
    int  b;
    logic toggle_mode;
    toggle_mode = 1'b0;
    for (b = 0; b < REG_W; b++)
      if (clr[b] && set[b])
        toggle_mode = 1'b1;
    next_value = cur;
    for (b = 0; b < REG_W; b++)
    begin
      if (toggle_mode)
        next_value[b] = (clr[b] && set[b]) ? ~cur[b] : cur[b];
      else if (clr[b])
        next_value[b] = 1'b0;
      else if (set[b])
        next_value[b] = 1'b1;
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare and report
  //////////////////////////////////////////////////////////////////////

  task automatic fail_value(input string name, input string what, input logic [7:0] exp,
                            input logic [7:0] act);
    $display("Fail %s %s expected %h actual %h", name, what, exp, act);
    test_errs++;
    err_cnt++;
  endtask

  task automatic check_regs();
    int n;
    for (n = 0; n < 8; n++)
      if (dut_value(n) !== model[n])
        fail_value(test_name, slot_name(n), 8'(model[n]), 8'(dut_value(n)));
  endtask

  task automatic end_test();
    $display("test %0d %s done, %0d errors", test_cnt, test_name, test_errs);
    test_cnt++;
    test_errs = 0;
  endtask

  // frame end, model moves first, DUT follows within 4 cycles
  task automatic close_frame();
    fw       = rx_word;
    rb_check = !spec_high && (bit_cnt >= FRAME_BITS);
    if (spec_high)
      test_name = "route";
    else if (bit_cnt != FRAME_BITS)
      test_name = $sformatf("bad length %0d", bit_cnt);
    else if (fw.raw.addr == ADDR_MUX)
    begin
      test_name = "mux load";
      model[slot_of(ADDR_MUX)] = fw.raw.data[REG_W-1:0];
    end
    else if (fw.wr.addr == ADDR_SOFT_RST)
    begin
      test_name = "soft reset";
      reset_model();
    end
    else if (slot_of(fw.wr.addr) >= 0)
    begin
      s = slot_of(fw.wr.addr);
      test_name = {"write ", slot_name(s)};
      model[s] = next_value(model[s], fw.wr.clr, fw.wr.set);
    end
    else
      test_name = $sformatf("unknown addr %0d", fw.wr.addr);
    chk_wait = 8;
  endtask

  task automatic finish_frame();
    check_regs();
    if (rb_check && rb_byte !== exp_rb)
      fail_value(test_name, "readback", exp_rb, rb_byte);
    end_test();
  endtask

  //////////////////////////////////////////////////////////////////////
  // pin monitor
  //////////////////////////////////////////////////////////////////////

  // pins move on falling clk, sampled here on rising
  always @(posedge clk)
  begin
    if (!arst_n)
    begin
      reset_model();
      sclk_q    = 1'b0;
      cs_n_q    = 1'b1;
      rx_word   = '0;
      rb_byte   = '0;
      exp_rb    = '0;
      spec_high = 1'b0;
      rb_check  = 1'b0;
      rst_done  = 1'b0;
      bit_cnt   = 0;
      chk_wait  = 0;
      test_errs = 0;
      test_cnt  = 0;
      err_cnt   = 0;
    end
    else
    begin
      if (!rst_done)
      begin
        test_name = "reset";
        check_regs();
        end_test();
        rst_done = 1'b1;
      end
      // router is pure gates off the pins
      if (special_n)
      begin
        exp_cs   = cs_n ? '1 : ~model[slot_of(ADDR_MUX)];
        exp_miso = |(model[slot_of(ADDR_MUX)] & periph_miso);
        if (periph_cs_n !== exp_cs)
          fail_value("route", "periph_cs_n", 8'(exp_cs), 8'(periph_cs_n));
        if (miso !== exp_miso)
          fail_value("route", "miso", 8'(exp_miso), 8'(miso));
      end
      if (!cs_n && cs_n_q)
      begin
        bit_cnt   = 0;
        rx_word   = '0;
        rb_byte   = '0;
        spec_high = special_n;
      end
      else if (!cs_n && special_n)
        spec_high = 1'b1;
      // rising sclk, mosi in, readback bit out of the second byte
      if (!cs_n && !special_n && sclk && !sclk_q)
      begin
        if (bit_cnt >= ADDR_BITS && bit_cnt < FRAME_BITS)
          rb_byte = {rb_byte[6:0], miso};
        rx_word = {rx_word[FRAME_BITS-2:0], mosi};
        if (bit_cnt <= FRAME_BITS)
          bit_cnt++;
        if (bit_cnt == ADDR_BITS)
          exp_rb = 8'(read_model(rx_word[7:0]));
      end
      if (cs_n && !cs_n_q)
        close_frame();
      else if (chk_wait > 0)
      begin
        chk_wait--;
        if (chk_wait == 0)
          finish_frame();
      end
      sclk_q = sclk;
      cs_n_q = cs_n;
    end
  end

endmodule

// File: test/smu_spi_tb.sv
// Testbench for the SMU SPI control block.
// Drives seeded random SPI frames into the register bank and through the
// peripheral router; the checker compares, this module prints the verdict.
`timescale 1ns/1ps

module smu_spi_tb
  import smu_regs_pkg::*;
  import spi_frame_pkg::*;
();

  localparam int CLK_HALF_NS   = 20;
  localparam int HALF_SCLK     = 4;
  localparam int IDLE_CYCLES   = 8;
  // frame counts per phase
  localparam int N_WRITES      = 40;
  localparam int N_MUX         = 4;
  localparam int N_UNKNOWN     = 3;
  localparam int N_BAD_LEN     = 2;
  localparam int N_LATE_WRITES = 8;
  localparam int N_ROUTE       = 8;
  localparam int N_FRAMES      = N_WRITES + N_MUX + N_UNKNOWN + N_BAD_LEN + 1
                                 + N_LATE_WRITES + 2 * N_ROUTE;
  // one frame is 16 bits of 8 clk plus select setup and idle gap
  localparam int TIMEOUT_CYCLES = N_FRAMES * (FRAME_BITS * 8 + 20) + 300;

  logic                clk;
  logic                arst_n;
  logic                sclk;
  logic                cs_n;
  logic                special_n;
  logic                mosi;
  logic                miso;
  logic [N_PERIPH-1:0] periph_cs_n;
  logic [N_PERIPH-1:0] periph_miso;
  logic [REG_W-1:0]    reg_led;
  logic [REG_W-1:0]    reg_mux;
  logic [REG_W-1:0]    reg_dac;
  logic [REG_W-1:0]    reg_rails;
  logic [REG_W-1:0]    reg_adc;
  logic [REG_W-1:0]    reg_clamp1;
  logic [REG_W-1:0]    reg_relay;
  logic [REG_W-1:0]    reg_rails_oe;
  int                  test_cnt;
  int                  err_cnt;
  int                  cycle_cnt = 0;

  smu_spi_top i_smu_spi_top (
    .clk          (clk),
    .arst_n       (arst_n),
    .sclk         (sclk),
    .cs_n         (cs_n),
    .special_n    (special_n),
    .mosi         (mosi),
    .miso         (miso),
    .periph_cs_n  (periph_cs_n),
    .periph_miso  (periph_miso),
    .reg_led      (reg_led),
    .reg_mux      (reg_mux),
    .reg_dac      (reg_dac),
    .reg_rails    (reg_rails),
    .reg_adc      (reg_adc),
    .reg_clamp1   (reg_clamp1),
    .reg_relay    (reg_relay),
    .reg_rails_oe (reg_rails_oe)
  );

  smu_spi_checker i_smu_spi_checker (
    .clk          (clk),
    .arst_n       (arst_n),
    .sclk         (sclk),
    .cs_n         (cs_n),
    .special_n    (special_n),
    .mosi         (mosi),
    .miso         (miso),
    .periph_miso  (periph_miso),
    .periph_cs_n  (periph_cs_n),
    .reg_led      (reg_led),
    .reg_mux      (reg_mux),
    .reg_dac      (reg_dac),
    .reg_rails    (reg_rails),
    .reg_adc      (reg_adc),
    .reg_clamp1   (reg_clamp1),
    .reg_relay    (reg_relay),
    .reg_rails_oe (reg_rails_oe),
    .test_cnt     (test_cnt),
    .err_cnt      (err_cnt)
  );

  //////////////////////////////////////////////////////////////////////
  // clock and run limit
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #(CLK_HALF_NS) clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, the frame sequence never finished", cycle_cnt);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // spi master
  //////////////////////////////////////////////////////////////////////

  // all pin changes land just after a falling clk edge
  // peripheral miso gets fresh random bits every cycle
  task automatic idle(input int n);
    repeat (n)
    begin
      @(negedge clk);
      periph_miso = 4'($urandom);
    end
  endtask

  // msb first, bits past the word are random filler
  task automatic send_frame(input logic spec_n, input logic [FRAME_BITS-1:0] word,
                            input int nbits);
    int i;
    special_n = spec_n;
    idle(2);
    cs_n = 1'b0;
    idle(2);
    for (i = 0; i < nbits; i++)
    begin
      if (i < FRAME_BITS)
        mosi = word[FRAME_BITS-1-i];
      else
        mosi = 1'($urandom);
      idle(HALF_SCLK);
      sclk = 1'b1;
      idle(HALF_SCLK);
      sclk = 1'b0;
    end
    idle(2);
    cs_n = 1'b1;
    mosi = 1'b0;
    idle(IDLE_CYCLES);
  endtask

  task automatic write_frame(input logic [7:0] addr, input logic [3:0] clr,
                             input logic [3:0] set);
    frame_word_u w;
    w.wr.addr = addr;
    w.wr.clr  = clr;
    w.wr.set  = set;
    send_frame(1'b0, w, FRAME_BITS);
  endtask

  task automatic raw_frame(input logic [7:0] addr, input logic [7:0] data, input int nbits);
    frame_word_u w;
    w.raw.addr = addr;
    w.raw.data = data;
    send_frame(1'b0, w, nbits);
  endtask

  // the seven set/clear/toggle registers
  function automatic logic [7:0] update_addr(input int idx);
    case (idx)
      0:       update_addr = ADDR_LED;
      1:       update_addr = ADDR_DAC;
      2:       update_addr = ADDR_RAILS;
      3:       update_addr = ADDR_ADC;
      4:       update_addr = ADDR_CLAMP1;
      5:       update_addr = ADDR_RELAY;
      default: update_addr = ADDR_RAILS_OE;
    endcase
  endfunction

  task automatic random_write();
    write_frame(update_addr(int'($urandom % 7)), 4'($urandom), 4'($urandom));
  endtask

  // one-hot low nibble keeps a single peripheral selected
  task automatic mux_load();
    raw_frame(ADDR_MUX, {4'($urandom), 4'(1 << ($urandom % 4))}, FRAME_BITS);
  endtask

  //////////////////////////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int         i;
    int         assert_fails;
    logic [7:0] a;
    void'($urandom(32'h9c7c));
    arst_n      = 1'b0;
    sclk        = 1'b0;
    cs_n        = 1'b1;
    special_n   = 1'b1;
    mosi        = 1'b0;
    periph_miso = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    idle(4);

    for (i = 0; i < N_WRITES; i++)
      random_write();
    for (i = 0; i < N_MUX; i++)
      mux_load();
    // top bit set lands outside the map
    for (i = 0; i < N_UNKNOWN; i++)
    begin
      a = 8'($urandom) | 8'h80;
      write_frame(a, 4'($urandom), 4'($urandom));
    end
    // one short, one long, both would toggle every led bit
    for (i = 0; i < N_BAD_LEN; i++)
      raw_frame(ADDR_LED, 8'hff, (i == 0) ? FRAME_BITS - 1 : FRAME_BITS + 1);
    raw_frame(ADDR_SOFT_RST, 8'($urandom), FRAME_BITS);
    for (i = 0; i < N_LATE_WRITES; i++)
      random_write();
    // pass-through frames with special_n high
    for (i = 0; i < N_ROUTE; i++)
    begin
      mux_load();
      send_frame(1'b1, 16'($urandom), FRAME_BITS);
    end
    idle(12);

    assert_fails = i_smu_spi_top.i_smu_spi_assertions.fail_cnt;
    $display("summary: %0d tests, %0d errors, %0d assertion failures",
             test_cnt, err_cnt, assert_fails);
    if (err_cnt == 0 && assert_fails == 0 && test_cnt == N_FRAMES + 1)
      $display("SIMULATION PASSED");
    else
    begin
      if (test_cnt != N_FRAMES + 1)
        $display("expected %0d tests but the checker finished %0d", N_FRAMES + 1, test_cnt);
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
